// ==== conv_pw_defs.svh ====
`ifndef CONV_PW_DEFS_SVH
`define CONV_PW_DEFS_SVH

// feature map geometry
`define LWIDTH  8   // height and width fields
`define FEASIZE 10  // feature memory address, 1024 pixels max

// pipeline depths
`define D_CONV  2   // operand register + product register
`define D_ACCUM 1   // output register after the memory read

// datapath widths, all signed
`define PIX_W   8
`define FEAT_W  24

`endif

// ==== conv_pw_pkg.sv ====
`include "conv_pw_defs.svh"

package conv_pw_pkg;

  // phase of the surrounding core, driven from outside
  typedef enum logic [1:0] {
    CORE_WAIT    = 2'd0,
    CORE_NETWORK = 2'd1,
    CORE_INPUT   = 2'd2,
    CORE_OUTPUT  = 2'd3
  } core_state_t;

  // stream framing strobes
  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } ctrl_t;

  typedef logic signed [`PIX_W-1:0]   pix_t;   // pixel or weight
  typedef logic signed [2*`PIX_W-1:0] prod_t;  // full precision product
  typedef logic signed [`FEAT_W-1:0]  feat_t;  // accumulated feature

endpackage

// ==== delay_line.sv ====
`timescale 1ns/1ps

module delay_line #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic clk,
  input  logic xrst,
  input  T     d,
  output T     q
);

  T stage [DEPTH];  // stage[0] sees d first

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= d;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign q = stage[DEPTH-1];

endmodule

// ==== conv_mac.sv ====
`timescale 1ns/1ps
`include "conv_pw_defs.svh"

module conv_mac (
  input  logic                clk,
  input  logic                xrst,
  input  conv_pw_pkg::pix_t   pixel,
  input  conv_pw_pkg::pix_t   weight,
  output conv_pw_pkg::prod_t  prod
);

  import conv_pw_pkg::*;

  pix_t  pixel_q;
  pix_t  weight_q;
  prod_t prod_pipe [`D_CONV-1];  // product stages after the operand register

  always_ff @(posedge clk) begin
    if (!xrst) begin
      pixel_q  <= '0;
      weight_q <= '0;
    end else begin
      pixel_q  <= pixel;
      weight_q <= weight;
    end
  end

  // signed 8x8, both operands signed so the product sign extends
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < `D_CONV-1; i++) begin
        prod_pipe[i] <= '0;
      end
    end else begin
      prod_pipe[0] <= pixel_q * weight_q;
      for (int i = 1; i < `D_CONV-1; i++) begin
        prod_pipe[i] <= prod_pipe[i-1];
      end
    end
  end

  assign prod = prod_pipe[`D_CONV-2];

endmodule

// ==== feat_accum.sv ====
`timescale 1ns/1ps
`include "conv_pw_defs.svh"

module feat_accum (
  input  logic                 clk,
  input  logic                 xrst,
  input  conv_pw_pkg::prod_t   prod,
  input  logic                 mem_feat_we,
  input  logic                 mem_feat_rst,
  input  logic [`FEASIZE-1:0]  mem_feat_raddr,
  input  logic [`FEASIZE-1:0]  mem_feat_waddr,
  input  logic                 conv_oe,
  output conv_pw_pkg::feat_t   out_data
);

  import conv_pw_pkg::*;

  localparam int WORDS = 2 ** `FEASIZE;

  feat_t mem [WORDS];  // partial sums, one per pixel
  feat_t rdata;        // registered read word
  feat_t prod_ext;
  feat_t wdata;

  assign prod_ext = feat_t'(prod);  // sign extended to feature width

  // first channel loads the product, later channels add to the stored sum
  assign wdata = mem_feat_rst ? prod_ext : rdata + prod_ext;

  // ==================================================
  // feature memory, synchronous read
  // ==================================================

  always_ff @(posedge clk) begin
    if (mem_feat_we) begin
      mem[mem_feat_waddr] <= wdata;
    end
    rdata <= mem[mem_feat_raddr];
  end

  // output register, loaded one cycle before out_valid
  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_data <= '0;
    end else if (conv_oe) begin
      out_data <= rdata;
    end
  end

endmodule

// ==== conv_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_pw_defs.svh"

module conv_ctrl (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     in_start,
  input  logic                     in_valid,
  input  logic                     in_stop,
  input  conv_pw_pkg::core_state_t core_state,
  input  logic [`LWIDTH-1:0]       fea_height,
  input  logic [`LWIDTH-1:0]       fea_width,
  input  logic                     first_input,
  input  logic                     last_input,
  output logic                     mem_feat_we,
  output logic                     mem_feat_rst,
  output logic [`FEASIZE-1:0]      mem_feat_raddr,
  output logic [`FEASIZE-1:0]      mem_feat_waddr,
  output logic                     conv_oe,
  output logic                     out_start,
  output logic                     out_valid,
  output logic                     out_stop
);

  import conv_pw_pkg::*;

  localparam int OUT_DEPTH = `D_CONV + `D_ACCUM;

  typedef enum logic {
    S_WAIT,
    S_ACTIVE
  } state_t;

  state_t               state;
  core_state_t          core_q;
  logic                 wait_back;   // output sweep done, hold until next start
  logic                 first_q;
  logic                 last_q;
  logic [`LWIDTH-1:0]   height_q;
  logic [`LWIDTH-1:0]   width_q;
  logic [`LWIDTH-1:0]   conv_x;
  logic [`LWIDTH-1:0]   conv_y;
  logic                 x_last;
  logic                 y_last;
  logic                 out_issue;
  logic [`FEASIZE-1:0]  feat_addr;
  logic [1:0]           we_rst_d;    // {we, rst}
  logic [1:0]           we_rst_q;
  ctrl_t                ctrl_d;
  ctrl_t                ctrl_mid;
  ctrl_t                ctrl_out;

  // ==================================================
  // layer FSM and raster position
  // ==================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
    end else begin
      case (state)
        S_WAIT:   if (in_start) state <= S_ACTIVE;
        S_ACTIVE: if (out_stop) state <= S_WAIT;
        default:  state <= S_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      core_q  <= CORE_WAIT;
      first_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      core_q  <= core_state;
      first_q <= first_input;
      last_q  <= last_input;
    end
  end

  // dimensions only taken on the first start of a layer
  always_ff @(posedge clk) begin
    if (!xrst) begin
      height_q <= '0;
      width_q  <= '0;
    end else if (state == S_WAIT && in_start) begin
      height_q <= fea_height;
      width_q  <= fea_width;
    end
  end

  assign x_last    = (conv_x == width_q - 1'b1);
  assign y_last    = (conv_y == height_q - 1'b1);
  assign out_issue = (state == S_ACTIVE) && (core_q == CORE_OUTPUT) && !wait_back;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      conv_x <= '0;
      conv_y <= '0;
    end else if (out_issue) begin
      if (x_last) begin
        conv_x <= '0;
        if (y_last) begin
          conv_y <= '0;
        end else begin
          conv_y <= conv_y + 1'b1;
        end
      end else begin
        conv_x <= conv_x + 1'b1;
      end
    end else if (state != S_ACTIVE || core_q != CORE_OUTPUT) begin
      conv_x <= '0;
      conv_y <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wait_back <= 1'b0;
    end else if (in_start) begin
      wait_back <= 1'b0;
    end else if (out_issue && x_last && y_last) begin
      wait_back <= 1'b1;  // last result address issued
    end
  end

  // ==================================================
  // feature memory control
  // ==================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      feat_addr <= '0;
    end else if (in_stop || wait_back) begin
      feat_addr <= '0;
    end else if (core_q == CORE_INPUT && in_valid) begin
      feat_addr <= feat_addr + 1'b1;
    end else if (out_issue) begin
      feat_addr <= feat_addr + 1'b1;
    end
  end

  assign we_rst_d = {in_valid, in_valid && first_q};  // first channel overwrites

  delay_line #(.T(logic [1:0]), .DEPTH(`D_CONV)) u_we_dly (
    .clk  (clk),
    .xrst (xrst),
    .d    (we_rst_d),
    .q    (we_rst_q)
  );

  assign mem_feat_we  = we_rst_q[1];
  assign mem_feat_rst = we_rst_q[0];

  // read one cycle ahead of the write so the stored sum meets the product
  delay_line #(.T(logic [`FEASIZE-1:0]), .DEPTH(`D_CONV-1)) u_addr_dly (
    .clk  (clk),
    .xrst (xrst),
    .d    (feat_addr),
    .q    (mem_feat_raddr)
  );

  always_ff @(posedge clk) begin
    if (!xrst) begin
      mem_feat_waddr <= '0;
    end else begin
      mem_feat_waddr <= mem_feat_raddr;
    end
  end

  // ==================================================
  // output control
  // ==================================================

  assign ctrl_d.start = (state == S_ACTIVE) && in_stop && last_q;
  assign ctrl_d.valid = out_issue;
  assign ctrl_d.stop  = out_issue && x_last && y_last;

  delay_line #(.T(ctrl_t), .DEPTH(OUT_DEPTH-1)) u_out_dly (
    .clk  (clk),
    .xrst (xrst),
    .d    (ctrl_d),
    .q    (ctrl_mid)
  );

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ctrl_out <= '0;
    end else begin
      ctrl_out <= ctrl_mid;
    end
  end

  assign conv_oe   = ctrl_mid.valid;  // one cycle before out_valid
  assign out_start = ctrl_out.start;
  assign out_valid = ctrl_out.valid;
  assign out_stop  = ctrl_out.stop;

endmodule

// ==== conv_pw_top.sv ====
`timescale 1ns/1ps
`include "conv_pw_defs.svh"

module conv_pw_top (
  input  logic                     clk,
  input  logic                     xrst,
  input  conv_pw_pkg::core_state_t core_state,
  input  logic [`LWIDTH-1:0]       fea_height,
  input  logic [`LWIDTH-1:0]       fea_width,
  input  logic                     first_input,
  input  logic                     last_input,
  input  logic                     in_start,
  input  logic                     in_valid,
  input  logic                     in_stop,
  input  conv_pw_pkg::pix_t        pixel,
  input  conv_pw_pkg::pix_t        weight,
  output logic                     out_start,
  output logic                     out_valid,
  output logic                     out_stop,
  output conv_pw_pkg::feat_t       out_data
);

  import conv_pw_pkg::*;

  logic                 mem_feat_we;
  logic                 mem_feat_rst;
  logic [`FEASIZE-1:0]  mem_feat_raddr;
  logic [`FEASIZE-1:0]  mem_feat_waddr;
  logic                 conv_oe;
  prod_t                prod;  // D_CONV cycles after in_valid

  // ==================================================
  // control, runs alongside the multiplier
  // ==================================================

  conv_ctrl u_ctrl (
    .clk            (clk),
    .xrst           (xrst),
    .in_start       (in_start),
    .in_valid       (in_valid),
    .in_stop        (in_stop),
    .core_state     (core_state),
    .fea_height     (fea_height),
    .fea_width      (fea_width),
    .first_input    (first_input),
    .last_input     (last_input),
    .mem_feat_we    (mem_feat_we),
    .mem_feat_rst   (mem_feat_rst),
    .mem_feat_raddr (mem_feat_raddr),
    .mem_feat_waddr (mem_feat_waddr),
    .conv_oe        (conv_oe),
    .out_start      (out_start),
    .out_valid      (out_valid),
    .out_stop       (out_stop)
  );

  // ==================================================
  // datapath
  // ==================================================

  conv_mac u_mac (
    .clk    (clk),
    .xrst   (xrst),
    .pixel  (pixel),
    .weight (weight),
    .prod   (prod)
  );

  feat_accum u_accum (
    .clk            (clk),
    .xrst           (xrst),
    .prod           (prod),
    .mem_feat_we    (mem_feat_we),
    .mem_feat_rst   (mem_feat_rst),
    .mem_feat_raddr (mem_feat_raddr),
    .mem_feat_waddr (mem_feat_waddr),
    .conv_oe        (conv_oe),
    .out_data       (out_data)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset held over the first rising edges, released on a falling edge
  initial begin
    xrst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
  end

endmodule

// ==== conv_pw_sva.sv ====
`timescale 1ns/1ps
`include "conv_pw_defs.svh"

module conv_pw_sva (
  input logic                     clk,
  input logic                     xrst,
  input conv_pw_pkg::core_state_t core_state,
  input logic                     in_valid,
  input logic                     out_valid,
  input logic                     out_stop,
  input logic                     mem_feat_we,
  input logic                     mem_feat_rst
);

  import conv_pw_pkg::*;

  // results only stream while the core sits in the output phase
  a_valid_in_output: assert property (
    @(posedge clk) disable iff (!xrst) out_valid |-> core_state == CORE_OUTPUT
  ) else $error("out_valid seen outside the output phase");

  // stop rides on the last result of the sweep
  a_stop_with_valid: assert property (
    @(posedge clk) disable iff (!xrst) out_stop |-> out_valid ##1 !out_valid
  ) else $error("out_stop seen without out_valid or with results after it");

  // a clearing write lands D_CONV cycles after its pixel strobe
  a_rst_with_we: assert property (
    @(posedge clk) disable iff (!xrst)
      mem_feat_rst |-> mem_feat_we && $past(in_valid, `D_CONV)
  ) else $error("mem_feat_rst seen without a matching mem_feat_we");

endmodule

// ==== conv_pw_tb.sv ====
`timescale 1ns/1ps
`include "conv_pw_defs.svh"

module conv_pw_tb;

  import conv_pw_pkg::*;

  localparam int NUM_LAYERS = 4;
  localparam int MAX_PIX    = 64;
  // 4 channels of up to 64 pixels with gaps per layer, plus the output sweep and slack
  localparam int TIMEOUT_CYCLES = NUM_LAYERS * (4 * MAX_PIX * 3 + MAX_PIX + 50);

  logic                clk;
  logic                xrst;
  core_state_t         core_state;
  logic [`LWIDTH-1:0]  fea_height;
  logic [`LWIDTH-1:0]  fea_width;
  logic                first_input;
  logic                last_input;
  logic                in_start;
  logic                in_valid;
  logic                in_stop;
  pix_t                pixel;
  pix_t                weight;
  logic                out_start;
  logic                out_valid;
  logic                out_stop;
  feat_t               out_data;

  integer              seed = 25764;
  int                  cycle_cnt;
  logic [`FEAT_W-1:0]  model_sum [MAX_PIX];  // reference partial sums
  logic [`FEAT_W-1:0]  exp_q [$];            // expected results in raster order
  int                  exp_pixels;
  int                  layers_done;
  int                  start_seen;
  int                  valid_cnt;

  tb_clk_gen #(.PERIOD(40), .RESET_CYCLES(2)) u_clk (
    .clk  (clk),
    .xrst (xrst)
  );

  conv_pw_top DUT (
    .clk         (clk),
    .xrst        (xrst),
    .core_state  (core_state),
    .fea_height  (fea_height),
    .fea_width   (fea_width),
    .first_input (first_input),
    .last_input  (last_input),
    .in_start    (in_start),
    .in_valid    (in_valid),
    .in_stop     (in_stop),
    .pixel       (pixel),
    .weight      (weight),
    .out_start   (out_start),
    .out_valid   (out_valid),
    .out_stop    (out_stop),
    .out_data    (out_data)
  );

  bind conv_ctrl conv_pw_sva u_sva (
    .clk          (clk),
    .xrst         (xrst),
    .core_state   (core_state),
    .in_valid     (in_valid),
    .out_valid    (out_valid),
    .out_stop     (out_stop),
    .mem_feat_we  (mem_feat_we),
    .mem_feat_rst (mem_feat_rst)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    if (exp !== got) begin
      fail_run($sformatf("Mismatch %s exp 0x%0h got 0x%0h", name, exp, got));
    end
  endtask

  // ==================================================
  // stimulus
  // ==================================================

  task automatic drive_channel(input int n, input bit first, input bit last);
    int   gap;
    int   prod;
    pix_t px;
    pix_t wt;
    wt = pix_t'($random(seed));  // one weight per channel
    core_state  = CORE_INPUT;
    first_input = first;
    last_input  = last;
    in_start    = 1'b1;
    @(negedge clk);
    in_start = 1'b0;
    for (int i = 0; i < n; i++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge clk);
      px       = pix_t'($random(seed));
      pixel    = px;
      weight   = wt;
      in_valid = 1'b1;
      prod = int'(px) * int'(wt);
      if (first) begin
        model_sum[i] = prod[`FEAT_W-1:0];  // first channel overwrites
      end else begin
        model_sum[i] = model_sum[i] + prod[`FEAT_W-1:0];
      end
      @(negedge clk);
      in_valid = 1'b0;
    end
    in_stop = 1'b1;
    @(negedge clk);
    in_stop = 1'b0;
  endtask

  task automatic run_layer(input int idx);
    int h;
    int w;
    int nch;
    h = 1 + $unsigned($random(seed)) % 8;
    w = 1 + $unsigned($random(seed)) % 8;
    if (idx == 0) begin
      nch = 1;  // plain products on the first layer
    end else begin
      nch = 2 + $unsigned($random(seed)) % 3;
    end
    fea_height = h[`LWIDTH-1:0];
    fea_width  = w[`LWIDTH-1:0];
    for (int ch = 0; ch < nch; ch++) begin
      drive_channel(h * w, ch == 0, ch == nch - 1);
    end
    for (int i = 0; i < h * w; i++) begin
      exp_q.push_back(model_sum[i]);
    end
    exp_pixels = h * w;
    core_state = CORE_OUTPUT;
    while (layers_done <= idx) @(negedge clk);
    @(negedge clk);  // hold output state past the last strobe
    core_state = CORE_WAIT;
  endtask

  initial begin
    core_state  = CORE_WAIT;
    fea_height  = '0;
    fea_width   = '0;
    first_input = 1'b0;
    last_input  = 1'b0;
    in_start    = 1'b0;
    in_valid    = 1'b0;
    in_stop     = 1'b0;
    pixel       = '0;
    weight      = '0;
    exp_pixels  = 0;
    layers_done = 0;
    wait (xrst === 1'b1);
    @(negedge clk);
    for (int l = 0; l < NUM_LAYERS; l++) begin
      run_layer(l);
    end
    repeat (4) @(negedge clk);
    if (exp_q.size() == 0 && layers_done == NUM_LAYERS) begin
      $display("Done: no errors");
      $finish;
    end else begin
      fail_run("results still expected at the end of the run");
    end
  end

  // ==================================================
  // output monitor and timeout
  // ==================================================

  always @(negedge clk) begin : monitor
    logic [`FEAT_W-1:0] exp_word;
    if (!xrst) begin
      start_seen = 0;
      valid_cnt  = 0;
    end else begin
      if (out_start) begin
        check_value("out_start_count", 0, start_seen);
        check_value("out_valid_count", 0, valid_cnt);  // start must lead the results
        start_seen = start_seen + 1;
      end
      if (out_valid && exp_q.size() == 0) begin
        fail_run("out_valid arrived with no result expected");
      end else if (out_valid) begin
        check_value("out_start_count", 1, start_seen);
        exp_word = exp_q.pop_front();
        check_value("out_data", exp_word, out_data[`FEAT_W-1:0]);
        valid_cnt = valid_cnt + 1;
        check_value("out_stop", valid_cnt == exp_pixels, out_stop);
        if (out_stop) begin
          layers_done = layers_done + 1;
          start_seen  = 0;
          valid_cnt   = 0;
        end
      end else if (out_stop) begin
        fail_run("out_stop arrived without out_valid");
      end
    end
  end

  always @(posedge clk) begin
    if (!xrst) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        fail_run("timeout: outputs did not finish");
      end
    end
  end

endmodule

// ==== conv_pw.f ====
+incdir+.
conv_pw_pkg.sv
delay_line.sv
conv_mac.sv
feat_accum.sv
conv_ctrl.sv
conv_pw_top.sv
tb_clk_gen.sv
conv_pw_sva.sv
conv_pw_tb.sv
